//--- Bender.yml
package:
  name: motor_bank

sources:
  - hw/motor_pkg.sv
  - hw/sample_tick.sv
  - hw/glitch_filter.sv
  - hw/quad_decoder.sv
  - hw/pwm_generator.sv
  - hw/motor_channel.sv
  - hw/channel_readout.sv
  - hw/motor_bank.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_motor_bank.sv

//--- hw/channel_readout.sv
/*
 * channel status readout
 * registers the status of the channel chosen by sel;
 * selects past the last channel read back as zero
 */
module channel_readout
	import motor_pkg::*;
(
	input  logic                          fpga_clk_50,
	input  logic                          hps_fpga_reset_n,
	input  chan_status_t [NUM_MOTORS-1:0] chan_status,      // all channels
	input  chan_idx_t                     sel,
	output chan_status_t                  readout
);

	chan_status_t sel_status; // mux output
	logic         sel_valid;  // sel names a real channel

	assign sel_valid = (sel < NUM_MOTORS);

	// out of range select reads as zero
	always_comb
	begin
		if (sel_valid)
			sel_status = chan_status[sel];
		else
			sel_status = '0;
	end

	// one cycle from sel or status to readout
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
			readout <= '0;
		else
			readout <= sel_status;
	end

endmodule

//--- hw/glitch_filter.sv
/*
 * encoder line glitch filter
 * two-flop synchronizer, then a level only passes once it has
 * held for FILTER_CYCLES consecutive cycles; shorter pulses die here
 */
module glitch_filter
	import motor_pkg::*;
(
	input  logic fpga_clk_50,
	input  logic hps_fpga_reset_n,
	input  logic raw,              // async encoder pin
	output logic clean             // filtered level
);

	logic sync_q1; // first sync stage
	logic sync_q2; // second sync stage

	// cycles the synced level has disagreed with clean
	logic [$clog2(FILTER_CYCLES + 1) - 1:0] diff_cnt;

	// ==================================================
	// synchronizer
	// ==================================================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			sync_q1 <= 1'b0;
			sync_q2 <= 1'b0;
		end
		else
		begin
			sync_q1 <= raw;
			sync_q2 <= sync_q1;
		end
	end

	// ==================================================
	// stability counter
	// ==================================================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			diff_cnt <= '0;
			clean    <= 1'b0;
		end
		else if (sync_q2 == clean)
			diff_cnt <= '0; // back to old level, start over
		else if (diff_cnt == FILTER_CYCLES - 1)
		begin
			clean    <= sync_q2; // held long enough, accept
			diff_cnt <= '0;
		end
		else
			diff_cnt <= diff_cnt + 1'b1;
	end

endmodule

//--- hw/motor_bank.sv
/*
 * six-channel motor i/o bank
 * one sample tick shared by all channels, an array of identical
 * motor channels (encoder filter, decoder, speed, pwm) and a
 * registered readout of the selected channel's count and speed
 */
module motor_bank
	import motor_pkg::*;
(
	input  logic                   fpga_clk_50,
	input  logic                   hps_fpga_reset_n,
	input  logic [NUM_MOTORS-1:0]  enc_a,            // raw encoder a lines
	input  logic [NUM_MOTORS-1:0]  enc_b,            // raw encoder b lines
	input  duty_t [NUM_MOTORS-1:0] duty,             // per-motor duty
	output logic [NUM_MOTORS-1:0]  pwm,
	input  chan_idx_t              sel,              // readout channel
	output chan_status_t           readout
);

	logic                          sample_stb;  // 5 ms enable
	chan_status_t [NUM_MOTORS-1:0] chan_status; // per-channel count and speed

	// ==================================================
	// sample timing
	// ==================================================
	sample_tick tick0 (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.sample_stb       (sample_stb)
	);

	// ==================================================
	// motor channels
	// ==================================================
	for (genvar i = 0; i < NUM_MOTORS; i++)
	begin : g_chan
		motor_channel chan (
			.fpga_clk_50      (fpga_clk_50),
			.hps_fpga_reset_n (hps_fpga_reset_n),
			.sample_stb       (sample_stb),
			.enc_a            (enc_a[i]),
			.enc_b            (enc_b[i]),
			.duty             (duty[i]),
			.pwm              (pwm[i]),
			.status           (chan_status[i])
		);
	end

	// registered status readout
	channel_readout rd0 (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.chan_status      (chan_status),
		.sel              (sel),
		.readout          (readout)
	);

endmodule

//--- hw/motor_channel.sv
/*
 * single motor channel
 * two encoder line filters, quadrature decoder, speed sampler
 * and pwm output; speed is the count change between sample ticks
 */
module motor_channel
	import motor_pkg::*;
(
	input  logic         fpga_clk_50,
	input  logic         hps_fpga_reset_n,
	input  logic         sample_stb,       // shared 5 ms tick
	input  logic         enc_a,            // raw encoder lines
	input  logic         enc_b,
	input  duty_t        duty,
	output logic         pwm,
	output chan_status_t status
);

	logic   enc_a_clean; // filtered encoder lines
	logic   enc_b_clean;
	count_t count;       // live position
	count_t last_count;  // position at previous tick
	speed_t speed;       // last measured delta

	// ==================================================
	// encoder front end
	// ==================================================
	glitch_filter filt_a (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.raw              (enc_a),
		.clean            (enc_a_clean)
	);

	glitch_filter filt_b (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.raw              (enc_b),
		.clean            (enc_b_clean)
	);

	quad_decoder dec0 (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.enc_a            (enc_a_clean),
		.enc_b            (enc_b_clean),
		.count            (count)
	);

	// speed sampler, delta truncated to 16 bits
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			last_count <= '0;
			speed      <= '0;
		end
		else if (sample_stb)
		begin
			speed      <= speed_t'(count - last_count);
			last_count <= count; // reference for next period
		end
	end

	// live count, speed from the last tick
	assign status = '{count: count, speed: speed};

	// ==================================================
	// motor drive
	// ==================================================
	pwm_generator pwm0 (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.duty             (duty),
		.pwm              (pwm)
	);

endmodule

//--- hw/motor_pkg.sv
/*
 * motor i/o shared definitions
 * channel count, sample and filter timing, pwm frame length,
 * the vector types used across the motor datapath and the
 * per-channel status record seen by the readout
 */
package motor_pkg;

	// ==================================================
	// sizing and timing
	// ==================================================

	localparam int NUM_MOTORS    = 6;      // motor channels in the bank
	localparam int TICK_CYCLES   = 250000; // 5 ms at 50 MHz
	localparam int FILTER_CYCLES = 4;      // stable cycles before an encoder edge is taken
	localparam int PWM_PERIOD    = 256;    // clocks per pwm frame

	// ==================================================
	// vector types
	// ==================================================

	// encoder position, wraps silently
	typedef logic signed [31:0] count_t;

	// count delta per sample period
	// low 16 bits of the 32-bit difference
	typedef logic signed [15:0] speed_t;

	// pwm duty, 0 = off, 255 = high all but one cycle
	typedef logic [7:0] duty_t;

	// readout channel select
	typedef logic [2:0] chan_idx_t;

	// sample divider, wide enough for TICK_CYCLES-1
	typedef logic [17:0] tick_cnt_t;

	// ==================================================
	// channel status
	// ==================================================

	// live position plus last measured speed, 48 bits
	typedef struct packed {
		count_t count; // upper 32 bits
		speed_t speed; // lower 16 bits
	} chan_status_t;

endpackage

//--- hw/pwm_generator.sv
/*
 * pwm generator
 * free-running frame counter, duty latched at frame start,
 * output registered high for the first duty cycles of a frame
 */
module pwm_generator
	import motor_pkg::*;
(
	input  logic  fpga_clk_50,
	input  logic  hps_fpga_reset_n,
	input  duty_t duty,
	output logic  pwm
);

	duty_t frame_cnt; // position in frame
	duty_t duty_q;    // duty held for the current frame
	duty_t duty_cur;  // duty in force this cycle

	// new duty only at frame start, otherwise the held one
	assign duty_cur = (frame_cnt == '0) ? duty : duty_q;

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			frame_cnt <= '0;
			duty_q    <= '0;
			pwm       <= 1'b0;
		end
		else
		begin
			if (frame_cnt == duty_t'(PWM_PERIOD - 1))
				frame_cnt <= '0; // end of frame
			else
				frame_cnt <= frame_cnt + 1'b1;
			duty_q <= duty_cur;
			pwm    <= (frame_cnt < duty_cur); // one cycle behind the counter
		end
	end

endmodule

//--- hw/quad_decoder.sv
/*
 * quadrature decoder
 * compares the filtered {a,b} pair against the previous one;
 * a forward gray step adds one to the position, a reverse step
 * subtracts one, a double change is dropped
 */
module quad_decoder
	import motor_pkg::*;
(
	input  logic   fpga_clk_50,
	input  logic   hps_fpga_reset_n,
	input  logic   enc_a,
	input  logic   enc_b,
	output count_t count           // signed position
);

	logic [1:0] prev_ab; // last sampled {a,b}
	logic [1:0] cur_ab;  // current {a,b}
	logic       step_up; // forward step seen
	logic       step_dn; // reverse step seen

	assign cur_ab = {enc_a, enc_b};

	// forward order 00 -> 10 -> 11 -> 01 -> 00
	always_comb
	begin
		step_up = 1'b0;
		step_dn = 1'b0;
		case ({prev_ab, cur_ab})
			4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00:
				step_up = 1'b1;
			4'b10_00, 4'b11_10, 4'b01_11, 4'b00_01:
				step_dn = 1'b1;
			default: ; // no change, or both lines flipped
		endcase
	end

	// ==================================================
	// position register
	// ==================================================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			prev_ab <= 2'b00; // filters also come out of reset low
			count   <= '0;
		end
		else
		begin
			prev_ab <= cur_ab;
			if (step_up)
				count <= count + 1;
			else if (step_dn)
				count <= count - 1;
		end
	end

endmodule

//--- hw/sample_tick.sv
/*
 * sample period tick
 * divides the board clock down to a one-cycle enable pulse
 * every TICK_CYCLES clocks; all channels sample speed on it
 */
module sample_tick
	import motor_pkg::*;
(
	input  logic fpga_clk_50,
	input  logic hps_fpga_reset_n,
	output logic sample_stb        // one cycle wide
);

	tick_cnt_t tick_cnt; // free-running divider

	// enable pulse instead of a divided clock
	// keeps speed sampling in the fpga_clk_50 domain
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			tick_cnt   <= '0;
			sample_stb <= 1'b0;
		end
		else if (tick_cnt == tick_cnt_t'(TICK_CYCLES - 1))
		begin
			tick_cnt   <= '0;   // wrap
			sample_stb <= 1'b1; // pulse on wrap
		end
		else
		begin
			tick_cnt   <= tick_cnt + 1'b1;
			sample_stb <= 1'b0;
		end
	end

endmodule

//--- sim/tb_clock_gen.sv
/*
 * testbench clock and reset
 * period-8 board clock, reset held low for the first 10 cycles
 * and released on a falling edge
 */
module tb_clock_gen
(
	output logic fpga_clk_50,
	output logic hps_fpga_reset_n
);

	initial
	begin
		fpga_clk_50      = 1'b0;
		hps_fpga_reset_n = 1'b0; // in reset from time zero
		repeat (10) @(posedge fpga_clk_50);
		@(negedge fpga_clk_50);
		hps_fpga_reset_n = 1'b1; // release away from the sampling edge
	end

	always #4 fpga_clk_50 = ~fpga_clk_50; // half of the 8 unit period

endmodule

//--- sim/tb_motor_bank.sv
/*
 * motor bank testbench
 * random quadrature steps and short glitches per channel, checked
 * against a count model; speed checked after each sample tick,
 * pwm high time per frame checked against random duty values
 */
module tb_motor_bank
	import motor_pkg::*;
();

	localparam int     NUM_TICKS = 3; // sample periods exercised
	localparam longint TIMEOUT   = longint'(NUM_TICKS + 2) * TICK_CYCLES * 8;

	logic                   fpga_clk_50;
	logic                   hps_fpga_reset_n;
	logic [NUM_MOTORS-1:0]  enc_a;
	logic [NUM_MOTORS-1:0]  enc_b;
	duty_t [NUM_MOTORS-1:0] duty;
	logic [NUM_MOTORS-1:0]  pwm;
	chan_idx_t              sel;
	chan_status_t           readout;

	logic [31:0] rng_state;                 // xorshift state
	int          errors;
	int          checks;
	int          cycle_cnt;                 // clocks since reset release
	count_t      exp_count[NUM_MOTORS];     // model position
	count_t      tick_count[NUM_MOTORS];    // model position at last tick
	int          phase[NUM_MOTORS];         // index into gray sequence

	tb_clock_gen clk0 (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n)
	);

	motor_bank dut0 (
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.enc_a            (enc_a),
		.enc_b            (enc_b),
		.duty             (duty),
		.pwm              (pwm),
		.sel              (sel),
		.readout          (readout)
	);

	// tick n falls after cycle n*TICK_CYCLES
	always @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
			cycle_cnt <= 0;
		else
			cycle_cnt <= cycle_cnt + 1;
	end

	// ==================================================
	// helpers
	// ==================================================

	function automatic logic [31:0] rand_next();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// {a,b} for each position in forward order
	function automatic logic [1:0] gray_ab(input int idx);
		case (idx)
			0:       return 2'b00;
			1:       return 2'b10;
			2:       return 2'b11;
			default: return 2'b01;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, act);
		end
	endtask

	// called and returns on a falling edge
	task automatic read_channel(input int ch, output chan_status_t st);
		sel = chan_idx_t'(ch);
		@(negedge fpga_clk_50); // readout registered once in between
		st = readout;
	endtask

	task automatic step_encoder(input int ch, input bit fwd);
		chan_status_t st;
		logic [1:0]   ab;
		phase[ch] = fwd ? (phase[ch] + 1) % 4 : (phase[ch] + 3) % 4;
		ab        = gray_ab(phase[ch]);
		enc_a[ch] = ab[1];
		enc_b[ch] = ab[0];
		exp_count[ch] = fwd ? exp_count[ch] + 1 : exp_count[ch] - 1;
		repeat (16) @(negedge fpga_clk_50); // filter plus decoder latency
		read_channel(ch, st);
		check_value($sformatf("readout.count[%0d]", ch), exp_count[ch], st.count);
	endtask

	// short pulse that must not reach the decoder
	// checked every cycle since a pulse that got through steps out and back
	task automatic glitch_line(input int ch, input bit line_b, input int len);
		int i;
		sel = chan_idx_t'(ch);
		@(negedge fpga_clk_50); // readout now follows this channel
		for (i = 0; i < len + 16; i++)
		begin
			if (i == 0 || i == len) // pulse start and end
			begin
				if (line_b)
					enc_b[ch] = ~enc_b[ch];
				else
					enc_a[ch] = ~enc_a[ch];
			end
			@(negedge fpga_clk_50);
			check_value($sformatf("readout.count[%0d] after glitch", ch), exp_count[ch],
				readout.count);
		end
	endtask

	task automatic run_steps(input int n_seq);
		int ch;
		int n;
		int s;
		int i;
		bit fwd;
		for (s = 0; s < n_seq; s++)
		begin
			ch  = rand_next() % NUM_MOTORS;
			fwd = rand_next() % 2;
			n   = 1 + rand_next() % 8;
			for (i = 0; i < n; i++)
			begin
				step_encoder(ch, fwd);
				if (rand_next() % 3 == 0) // glitch between some steps
					glitch_line(ch, rand_next() % 2, 1 + rand_next() % (FILTER_CYCLES - 1));
			end
		end
	endtask

	// speed after tick k against the model's count history
	task automatic check_tick(input int k);
		chan_status_t st;
		speed_t       exp_speed;
		int           ch;
		if (cycle_cnt >= k * TICK_CYCLES)
		begin
			errors++;
			$display("encoder activity ran past sample tick %0d, speed model invalid", k);
		end
		while (cycle_cnt < k * TICK_CYCLES + 8)
			@(negedge fpga_clk_50);
		for (ch = 0; ch < NUM_MOTORS; ch++)
		begin
			exp_speed      = speed_t'(exp_count[ch] - tick_count[ch]); // low 16 bits
			tick_count[ch] = exp_count[ch];
			read_channel(ch, st);
			check_value($sformatf("readout.speed[%0d] tick %0d", ch, k), exp_speed, st.speed);
			check_value($sformatf("readout.count[%0d] tick %0d", ch, k), exp_count[ch],
				st.count);
		end
	endtask

	task automatic check_pwm(input bit extremes);
		duty_t d[NUM_MOTORS];
		int    hi[NUM_MOTORS];
		int    ch;
		for (ch = 0; ch < NUM_MOTORS; ch++)
		begin
			d[ch]  = duty_t'(rand_next());
			hi[ch] = 0;
		end
		if (extremes)
		begin
			d[0] = 8'h00; // never high
			d[1] = 8'hff; // low one cycle per frame
		end
		for (ch = 0; ch < NUM_MOTORS; ch++)
			duty[ch] = d[ch];
		repeat (PWM_PERIOD + 4) @(negedge fpga_clk_50); // settling frame
		repeat (PWM_PERIOD)
		begin
			@(negedge fpga_clk_50);
			for (ch = 0; ch < NUM_MOTORS; ch++)
				if (pwm[ch])
					hi[ch]++;
		end
		for (ch = 0; ch < NUM_MOTORS; ch++)
			check_value($sformatf("pwm[%0d] high cycles", ch), d[ch], hi[ch]);
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial
	begin
		int k;
		int s;
		enc_a     = '0;
		enc_b     = '0;
		duty      = '0;
		sel       = '0;
		rng_state = 32'hd300;
		errors    = 0;
		checks    = 0;
		for (k = 0; k < NUM_MOTORS; k++)
		begin
			exp_count[k]  = '0;
			tick_count[k] = '0;
			phase[k]      = 0;
		end
		@(posedge hps_fpga_reset_n);
		@(negedge fpga_clk_50);

		// reset state on every select
		check_value("pwm", '0, pwm);
		for (s = 0; s < 8; s++)
		begin
			sel = chan_idx_t'(s);
			@(negedge fpga_clk_50);
			check_value($sformatf("readout sel %0d after reset", s), '0, readout);
		end

		for (k = 1; k <= NUM_TICKS; k++)
		begin
			run_steps(8 + 2 * k);
			if (k == 1)
			begin
				check_pwm(1'b0);
				check_pwm(1'b1);
			end
			check_tick(k);
		end

		// selects past the last channel
		for (s = NUM_MOTORS; s < 8; s++)
		begin
			sel = chan_idx_t'(s);
			@(negedge fpga_clk_50);
			check_value($sformatf("readout sel %0d", s), '0, readout);
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog sized from the ticks under test
	initial
	begin
		#(TIMEOUT);
		$display("watchdog expired, run timed out before all tests finished");
		$display("Test failed");
		$finish;
	end

endmodule

//--- src.f
hw/motor_pkg.sv
hw/sample_tick.sv
hw/glitch_filter.sv
hw/quad_decoder.sv
hw/pwm_generator.sv
hw/motor_channel.sv
hw/channel_readout.sv
hw/motor_bank.sv
sim/tb_clock_gen.sv
sim/tb_motor_bank.sv
